// ==== common/cache_pkg.sv ====
/*
 * Cache directory geometry constants, the tag entry type and the pseudo-LRU tree type
 */

package cache_pkg;

	// Number of sets in the directory
	localparam int NUM_SETS = 32;

	// Set index width follows from the set count
	localparam int SET_INDEX_WIDTH = $clog2(NUM_SETS);

	// Width of the stored address tag
	localparam int TAG_WIDTH = 20;

	// Index of one of the four ways in a set
	typedef logic [1:0] way_t;

	// One directory entry holds a valid flag and the line's tag
	typedef struct packed {
		logic valid;
		logic [TAG_WIDTH-1:0] tag;
	} tag_entry_t;

	// Pseudo-LRU tree for one set
	// The root b selects between the pairs {0,1} and {2,3}
	// Node a picks within ways 0 and 1, node c picks within ways 2 and 3
	// A bit of 0 points at the left child and 1 at the right child
	typedef struct packed {
		logic a;
		logic b;
		logic c;
	} lru_tree_t;

endpackage

// ==== source/sram_1r1w.sv ====
/*
 * Register array with one read port and one write port, cleared on reset
 */

`timescale 1ns/100ps

module sram_1r1w
	#(parameter type payload_t = logic,
	parameter int SIZE = 32)
	(input logic clk,
	input logic reset,
	input logic rd_enable_i,
	input logic [$clog2(SIZE)-1:0] rd_addr_i,
	output payload_t rd_data_o,
	input logic wr_enable_i,
	input logic [$clog2(SIZE)-1:0] wr_addr_i,
	input payload_t wr_data_i);

	// Storage for every entry
	payload_t mem [SIZE];

	// A write in the same cycle as a read of that address must be visible
	// to the reader, so the written value bypasses the array
	logic bypass;

	assign bypass = wr_enable_i && (wr_addr_i == rd_addr_i);

	// Write port and array clear
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < SIZE; i++)
				mem[i] <= '0;
		end
		else if (wr_enable_i)
		begin
			mem[wr_addr_i] <= wr_data_i;
		end
	end

	// Registered read port
	// The output holds its last value while no read is enabled
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			rd_data_o <= '0;
		end
		else if (rd_enable_i)
		begin
			if (bypass)
				rd_data_o <= wr_data_i;
			else
				rd_data_o <= mem[rd_addr_i];
		end
	end

endmodule

// ==== cache_lru/cache_lru.sv ====
/*
 * Pseudo-LRU replacement state for every set, with victim decode and MRU update
 */

`timescale 1ns/100ps

module cache_lru
	import cache_pkg::*;
	(input logic clk,
	input logic reset,
	input logic access_i,
	input logic [SET_INDEX_WIDTH-1:0] set_i,
	input logic update_mru_i,
	input way_t new_mru_way_i,
	output way_t lru_way_o);

	// Tree of the set read on the last access
	lru_tree_t cur_tree;

	// Tree to write back once the accessed way becomes most recently used
	lru_tree_t next_tree;

	// Set of the access in flight, used as the write address for the update
	logic [SET_INDEX_WIDTH-1:0] set_latched;

	// The tree is read when the access arrives and is written back one cycle
	// later, so a following access to the same set gets the forwarded tree
	sram_1r1w #(.payload_t(lru_tree_t), .SIZE(NUM_SETS)) lru_data (
		.clk(clk),
		.reset(reset),
		.rd_enable_i(access_i),
		.rd_addr_i(set_i),
		.rd_data_o(cur_tree),
		.wr_enable_i(update_mru_i),
		.wr_addr_i(set_latched),
		.wr_data_i(next_tree));

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			set_latched <= '0;
		else if (access_i)
			set_latched <= set_i;
	end

	// Follow the node bits down to the least recently used leaf
	always_comb
	begin
		if (!cur_tree.b)
			lru_way_o = cur_tree.a ? way_t'(1) : way_t'(0);
		else
			lru_way_o = cur_tree.c ? way_t'(3) : way_t'(2);
	end

	// Point every node on the path of the touched way toward the other side
	// Nodes off that path keep their value
	always_comb
	begin
		next_tree = cur_tree;
		case (new_mru_way_i)
			2'd0:
			begin
				next_tree.a = 1'b1;
				next_tree.b = 1'b1;
			end
			2'd1:
			begin
				next_tree.a = 1'b0;
				next_tree.b = 1'b1;
			end
			2'd2:
			begin
				next_tree.b = 1'b0;
				next_tree.c = 1'b1;
			end
			default:
			begin
				next_tree.b = 1'b0;
				next_tree.c = 1'b0;
			end
		endcase
	end

endmodule

// ==== cache_tag/cache_tag.sv ====
/*
 * Four-way tag storage with hit detection, victim readout and fill writes
 */

`timescale 1ns/100ps

module cache_tag
	import cache_pkg::*;
	(input logic clk,
	input logic reset,
	input logic access_i,
	input logic [SET_INDEX_WIDTH-1:0] set_i,
	input logic [TAG_WIDTH-1:0] tag_i,
	input logic fill_i,
	input way_t fill_way_i,
	input way_t victim_way_i,
	output logic hit_o,
	output way_t hit_way_o,
	output logic evict_valid_o,
	output logic [TAG_WIDTH-1:0] evict_tag_o);

	// Entries of the looked-up set, one per way
	tag_entry_t way_entry [4];

	// Per-way match of the requested tag
	logic [3:0] way_hit;

	// Per-way write enable for the fill
	logic [3:0] way_fill;

	// Set and tag of the lookup in flight
	logic [SET_INDEX_WIDTH-1:0] set_latched;
	logic [TAG_WIDTH-1:0] tag_latched;

	// Entry written on a fill, always valid and carrying the requested tag
	tag_entry_t fill_entry;

	assign fill_entry.valid = 1'b1;
	assign fill_entry.tag = tag_latched;

	// The fill writes back to the latched set one cycle after the access
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			set_latched <= '0;
		else if (access_i)
			set_latched <= set_i;
	end

	// The requested tag feeds the way comparison and the fill entry
	always_ff @(posedge clk)
	begin
		if (access_i)
			tag_latched <= tag_i;
	end

	// One storage array per way, all read together on each access
	for (genvar w = 0; w < 4; w++)
	begin : g_way
		// Only the chosen way takes the fill
		assign way_fill[w] = fill_i && (fill_way_i == way_t'(w));

		sram_1r1w #(.payload_t(tag_entry_t), .SIZE(NUM_SETS)) tag_data (
			.clk(clk),
			.reset(reset),
			.rd_enable_i(access_i),
			.rd_addr_i(set_i),
			.rd_data_o(way_entry[w]),
			.wr_enable_i(way_fill[w]),
			.wr_addr_i(set_latched),
			.wr_data_i(fill_entry));

		// A way hits when it is valid and its tag equals the request
		assign way_hit[w] = way_entry[w].valid && (way_entry[w].tag == tag_latched);
	end

	// Encode the hitting way
	// Fills happen only on a miss, so at most one way can match
	always_comb
	begin
		hit_o = |way_hit;
		hit_way_o = '0;
		for (int w = 0; w < 4; w++)
		begin
			if (way_hit[w])
				hit_way_o = way_t'(w);
		end
	end

	// Report what the replacement choice would displace
	assign evict_valid_o = way_entry[victim_way_i].valid;
	assign evict_tag_o = way_entry[victim_way_i].tag;

endmodule

// ==== source/cache_directory.sv ====
/*
 * Tag directory top level
 * Sequences the lookup, the replacement choice, the fill and the MRU update
 */

`timescale 1ns/100ps

module cache_directory
	import cache_pkg::*;
	(input logic clk,
	input logic reset,
	input logic access_i,
	input logic [SET_INDEX_WIDTH-1:0] set_i,
	input logic [TAG_WIDTH-1:0] tag_i,
	output logic lookup_done_o,
	output logic hit_o,
	output way_t way_o,
	output logic evict_o,
	output logic [TAG_WIDTH-1:0] evict_tag_o);

	// High in the cycle after an access, when the stored state has been read
	logic lookup_valid;

	// Raw results from the tag ways
	logic tag_hit;
	way_t hit_way;
	logic evict_valid;

	// Least recently used way of the looked-up set
	way_t lru_way;

	// Fill and update strobes for the completing lookup
	logic fill;
	logic update_mru;

	// Way that becomes most recently used
	way_t mru_way;

	// Track which cycles carry a completed lookup
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			lookup_valid <= 1'b0;
		else
			lookup_valid <= access_i;
	end

	// A miss allocates into the way the tree names
	assign fill = lookup_valid && !tag_hit;

	// Every completed lookup touches a way, the hit way or the freshly filled one
	assign update_mru = lookup_valid;
	assign mru_way = tag_hit ? hit_way : lru_way;

	// Tag storage
	// The victim way and the fill way are both the LRU way, since a fill only
	// ever goes where the tree points
	cache_tag tag_ways (
		.clk(clk),
		.reset(reset),
		.access_i(access_i),
		.set_i(set_i),
		.tag_i(tag_i),
		.fill_i(fill),
		.fill_way_i(lru_way),
		.victim_way_i(lru_way),
		.hit_o(tag_hit),
		.hit_way_o(hit_way),
		.evict_valid_o(evict_valid),
		.evict_tag_o(evict_tag_o));

	// Replacement state
	cache_lru lru (
		.clk(clk),
		.reset(reset),
		.access_i(access_i),
		.set_i(set_i),
		.update_mru_i(update_mru),
		.new_mru_way_i(mru_way),
		.lru_way_o(lru_way));

	// Results are only meaningful while the lookup completes
	assign lookup_done_o = lookup_valid;
	assign hit_o = lookup_valid && tag_hit;

	// On a hit this is where the line lives, on a miss where it goes
	assign way_o = mru_way;

	// An eviction is reported when the fill overwrites a valid line
	assign evict_o = fill && evict_valid;

endmodule

// ==== dv/tb_clock_gen.sv ====
/*
 * Testbench clock and power-on reset generator
 */

`timescale 1ns/100ps

module tb_clock_gen
	(output logic clk_o,
	output logic reset_o);

	// 40 ns clock period
	localparam int CLK_PERIOD = 40;

	// Reset stays high for this many rising edges
	localparam int RESET_CYCLES = 8;

	initial
	begin
		clk_o = 1'b0;
		forever
			#(CLK_PERIOD / 2) clk_o = ~clk_o;
	end

	// Release reset on a rising edge so it lines up with the stimulus
	initial
	begin
		reset_o = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_o);
		reset_o <= 1'b0;
	end

endmodule

// ==== dv/cache_directory_sva.sv ====
/*
 * Protocol assertions for the directory lookup pulse and eviction flag
 */

`timescale 1ns/100ps

module cache_directory_sva
	(input logic clk,
	input logic reset,
	input logic access_i,
	input logic lookup_done_i,
	input logic hit_i,
	input logic evict_i);

	// Every access completes on the following edge
	done_after_access: assert property (@(posedge clk) disable iff (reset)
		access_i |=> lookup_done_i)
		else $error("lookup_done_o missing one cycle after access_i");

	// No completion without an access one cycle earlier
	no_spurious_done: assert property (@(posedge clk) disable iff (reset)
		!access_i |=> !lookup_done_i)
		else $error("lookup_done_o high without a preceding access_i");

	// An eviction only happens on a miss
	evict_is_miss: assert property (@(posedge clk) disable iff (reset)
		evict_i |-> !hit_i)
		else $error("evict_o high together with hit_o");

	// An eviction belongs to a completing lookup
	evict_with_done: assert property (@(posedge clk) disable iff (reset)
		evict_i |-> lookup_done_i)
		else $error("evict_o high outside a lookup completion");

	// The completion pulse stays low throughout reset
	quiet_in_reset: assert property (@(posedge clk)
		reset |-> !lookup_done_i)
		else $error("lookup_done_o high while reset is asserted");

endmodule

bind cache_directory cache_directory_sva sva (
	.clk(clk),
	.reset(reset),
	.access_i(access_i),
	.lookup_done_i(lookup_done_o),
	.hit_i(hit_o),
	.evict_i(evict_o));

// ==== dv/cache_directory_tb.sv ====
/*
 * Testbench for the cache tag directory
 * Directed and random lookups checked against a reference model of tags and trees
 */

`timescale 1ns/100ps

module cache_directory_tb
	import cache_pkg::*;
	();

	// Run length figures used for the timeout limit
	localparam int RESET_CYCLES = 8;
	localparam int DIRECTED_LOOKUPS = 23;
	localparam int RANDOM_LOOKUPS = 2000;
	localparam int MAX_GAP = 3;
	localparam int CYCLE_LIMIT = RESET_CYCLES
		+ (DIRECTED_LOOKUPS + RANDOM_LOOKUPS) * (MAX_GAP + 1) + 100;

	logic clk;
	logic reset;

	// DUT inputs
	logic access;
	logic [SET_INDEX_WIDTH-1:0] set_sel;
	logic [TAG_WIDTH-1:0] tag;

	// DUT outputs
	logic lookup_done;
	logic hit;
	way_t way;
	logic evict;
	logic [TAG_WIDTH-1:0] evict_tag;

	// A small pool makes hits and evictions frequent
	logic [TAG_WIDTH-1:0] tag_pool [6] = '{20'h0_1a2b, 20'h3_c4d5, 20'h7_e6f0,
		20'h9_0123, 20'hb_4567, 20'hf_89ab};

	// Reference model state, cleared like the DUT after reset
	logic model_valid [NUM_SETS][4];
	logic [TAG_WIDTH-1:0] model_tag [NUM_SETS][4];
	lru_tree_t model_tree [NUM_SETS];

	// Lookups issued but not yet completed, oldest first
	logic [SET_INDEX_WIDTH-1:0] pend_set [$];
	logic [TAG_WIDTH-1:0] pend_tag [$];

	// Monitor working values
	logic [SET_INDEX_WIDTH-1:0] req_set;
	logic [TAG_WIDTH-1:0] req_tag;
	logic exp_hit;
	way_t exp_way;
	logic exp_evict;
	logic [TAG_WIDTH-1:0] exp_evict_tag;

	// Results of the most recent completion, for the directed checks
	logic last_hit;
	way_t last_way;
	logic last_evict;
	logic [TAG_WIDTH-1:0] last_evict_tag;
	way_t filled_way;

	string test_name = "reset";
	integer seed = 32'h104f;
	int value_errors = 0;
	int protocol_errors = 0;
	int lookups_checked = 0;
	int cycle_count = 0;

	tb_clock_gen clock_gen (
		.clk_o(clk),
		.reset_o(reset));

	cache_directory uut (
		.clk(clk),
		.reset(reset),
		.access_i(access),
		.set_i(set_sel),
		.tag_i(tag),
		.lookup_done_o(lookup_done),
		.hit_o(hit),
		.way_o(way),
		.evict_o(evict),
		.evict_tag_o(evict_tag));

	// Root b picks the half, then a or c picks the way within it
	function automatic way_t victim_of(input lru_tree_t t);
		way_t w;
		if (t.b)
			w = {1'b1, t.c};
		else
			w = {1'b0, t.a};
		return w;
	endfunction

	// Point the root and the touched half's node away from the touched way
	function automatic lru_tree_t touched(input lru_tree_t t, input way_t w);
		lru_tree_t n;
		n = t;
		n.b = !w[1];
		if (w[1])
			n.c = !w[0];
		else
			n.a = !w[0];
		return n;
	endfunction

	task automatic value_error(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("ERROR %s: %s expected %0h actual %0h", test_name, what, expected, actual);
		value_errors++;
	endtask

	// Called on a rising edge, returns one edge later with the lookup sampled
	task automatic drive_lookup(input logic [SET_INDEX_WIDTH-1:0] s,
		input logic [TAG_WIDTH-1:0] t);
		access <= 1'b1;
		set_sel <= s;
		tag <= t;
		pend_set.push_back(s);
		pend_tag.push_back(t);
		@(posedge clk);
	endtask

	task automatic idle(input int n);
		access <= 1'b0;
		repeat (n) @(posedge clk);
	endtask

	// Stop issuing and wait for every outstanding lookup to complete
	task automatic wait_idle();
		access <= 1'b0;
		while (pend_set.size() != 0)
			@(posedge clk);
	endtask

	task automatic expect_hit(input way_t w);
		assert (last_hit == 1'b1)
			else value_error("hit_o", 1, last_hit);
		assert (last_way == w)
			else value_error("way_o", w, last_way);
	endtask

	// Outputs are compared on the falling edge, away from the driving edge
	always @(negedge clk)
	begin
		if (!reset && lookup_done)
		begin
			assert (pend_set.size() != 0)
			else
			begin
				$display("ERROR %s: lookup_done_o pulsed with no lookup outstanding",
					test_name);
				protocol_errors++;
			end
			if (pend_set.size() != 0)
			begin
				req_set = pend_set.pop_front();
				req_tag = pend_tag.pop_front();
				// A miss goes to the way the tree names
				exp_hit = 1'b0;
				exp_way = victim_of(model_tree[req_set]);
				for (int w = 0; w < 4; w++)
				begin
					if (model_valid[req_set][w] && model_tag[req_set][w] == req_tag)
					begin
						exp_hit = 1'b1;
						exp_way = way_t'(w);
					end
				end
				exp_evict = !exp_hit && model_valid[req_set][exp_way];
				exp_evict_tag = model_tag[req_set][exp_way];
				assert (hit == exp_hit)
					else value_error("hit_o", exp_hit, hit);
				assert (way == exp_way)
					else value_error("way_o", exp_way, way);
				assert (evict == exp_evict)
					else value_error("evict_o", exp_evict, evict);
				if (exp_evict)
					assert (evict_tag == exp_evict_tag)
						else value_error("evict_tag_o", exp_evict_tag, evict_tag);
				lookups_checked++;
				last_hit = hit;
				last_way = way;
				last_evict = evict;
				last_evict_tag = evict_tag;
				// Fill on a miss, then the accessed way becomes most recently used
				if (!exp_hit)
				begin
					model_valid[req_set][exp_way] = 1'b1;
					model_tag[req_set][exp_way] = req_tag;
					filled_way = exp_way;
				end
				model_tree[req_set] = touched(model_tree[req_set], exp_way);
			end
		end
	end

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT)
		begin
			$display("Timeout after %0d cycles with %0d lookups outstanding",
				cycle_count, pend_set.size());
			$display("TEST FAILED");
			$finish;
		end
	end

	initial
	begin
		int cold_sets [4];
		way_t fill_way;
		way_t exp_victim;
		logic [TAG_WIDTH-1:0] victim_tag;
		logic [31:0] rnd;
		int gap;
		access = 1'b0;
		set_sel = '0;
		tag = '0;
		cold_sets = '{0, 5, 17, 31};
		for (int s = 0; s < NUM_SETS; s++)
		begin
			model_tree[s] = '0;
			for (int w = 0; w < 4; w++)
			begin
				model_valid[s][w] = 1'b0;
				model_tag[s][w] = '0;
			end
		end
		@(negedge reset);
		@(posedge clk);

		// First touch of a set misses into way 0 and displaces nothing
		test_name = "cold_start";
		for (int i = 0; i < 4; i++)
		begin
			drive_lookup(cold_sets[i], tag_pool[i]);
			wait_idle();
			assert ({last_hit, last_way, last_evict} == 4'b0)
				else value_error("{hit,way,evict}", 0, {last_hit, last_way, last_evict});
		end

		// A repeated tag must hit where the model placed it
		test_name = "hit_after_fill";
		for (int i = 0; i < 2; i++)
		begin
			drive_lookup(9, tag_pool[i]);
			wait_idle();
			fill_way = filled_way;
			drive_lookup(9, tag_pool[i]);
			wait_idle();
			expect_hit(fill_way);
		end

		// Four fills take every way, the fifth evicts the tree's victim
		test_name = "plru_order";
		for (int i = 0; i < 4; i++)
		begin
			drive_lookup(12, tag_pool[i]);
			wait_idle();
		end
		exp_victim = victim_of(model_tree[12]);
		victim_tag = model_tag[12][exp_victim];
		drive_lookup(12, tag_pool[4]);
		wait_idle();
		assert (last_way == exp_victim)
			else value_error("way_o", exp_victim, last_way);
		assert (last_evict == 1'b1)
			else value_error("evict_o", 1, last_evict);
		assert (last_evict_tag == victim_tag)
			else value_error("evict_tag_o", victim_tag, last_evict_tag);

		// Consecutive cycles on one set rely on the write forwarding
		test_name = "back_to_back";
		for (int i = 0; i < 10; i++)
		begin
			rnd = {$random(seed)} % 6;
			drive_lookup((i % 4 == 3) ? 21 : 20, tag_pool[rnd]);
		end
		wait_idle();

		test_name = "random_mix";
		for (int n = 0; n < RANDOM_LOOKUPS; n++)
		begin
			rnd = $random(seed);
			drive_lookup(rnd[SET_INDEX_WIDTH-1:0], tag_pool[{$random(seed)} % 6]);
			gap = {$random(seed)} % (MAX_GAP + 1);
			if (gap > 0)
				idle(gap);
		end
		wait_idle();

		$display("Lookups checked: %0d, value errors: %0d, protocol errors: %0d",
			lookups_checked, value_errors, protocol_errors);
		if (value_errors == 0 && protocol_errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== all.f ====
common/cache_pkg.sv
source/sram_1r1w.sv
cache_lru/cache_lru.sv
cache_tag/cache_tag.sv
source/cache_directory.sv
dv/tb_clock_gen.sv
dv/cache_directory_sva.sv
dv/cache_directory_tb.sv
